/* files.f */
hdl/apbFabricPkg.sv
hdl/slotDecoder.sv
hdl/indirectAddrReg.sv
hdl/responseMux.sv
hdl/apbFabric.sv
tests/apbFabricChecker.sv
tests/apbFabricTb.sv

/* run.sh */
#!/bin/sh
# Build and run the APB fabric testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --assert --top-module apbFabricTb -f files.f \
        --Mdir obj_dir -o apbFabricSim; then
    echo "Verilator build failed"
    exit 1
fi

simOut=$(./obj_dir/apbFabricSim)
simStatus=$?
printf '%s\n' "$simOut"

if [ "$simStatus" -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if printf '%s\n' "$simOut" | grep -qx "ALL TESTS PASSED"; then
    exit 0
fi

echo "Pass message not found in simulation output"
exit 1

/* tests/apbFabricTb.sv */
`timescale 1ns/1ps
`default_nettype none

module apbFabricTb;
    import apbFabricPkg::*;

    localparam int numRows      = 17;
    localparam int readyTimeout = 32;

    // One transfer per row, waits and err give the slave's answer
    typedef struct packed {
        logic [slotBits-1:0]   slot;
        logic [offsetBits-1:0] offset;
        logic                  write;
        logic                  rnd;
        logic [dataWidth-1:0]  wdata;
        logic [3:0]            waits;
        logic                  err;
    } rowT;

    logic                      pclk = 1'b0;
    logic                      rstN;
    apbReqT                    req;
    apbRespT                   resp;
    slaveReqT                  slaveReq;
    logic [numExtSlots-1:0]    slaveSel;
    apbRespT [numExtSlots-1:0] slaveResp;

    logic [3:0]                curWaits;
    logic                      curErr;
    logic [3:0]                waitCnt;
    logic [31:0]               rngState;
    int                        mismatches;
    int                        timeouts = 0;
    rowT                       rows [numRows];

    always #20 pclk = ~pclk;

    apbFabric u_dut
    (
        .pclk      (pclk),
        .rstN      (rstN),
        .req       (req),
        .resp      (resp),
        .slaveReq  (slaveReq),
        .slaveSel  (slaveSel),
        .slaveResp (slaveResp)
    );

    apbFabricChecker u_checker
    (
        .pclk       (pclk),
        .rstN       (rstN),
        .req        (req),
        .resp       (resp),
        .slaveReq   (slaveReq),
        .slaveSel   (slaveSel),
        .waits      (curWaits),
        .err        (curErr),
        .mismatches (mismatches)
    );

    // Access cycles seen by the selected slave
    always_ff @(posedge pclk)
    begin
        if (!rstN)
        begin
            waitCnt <= '0;
        end
        else if (!slaveReq.enable)
        begin
            waitCnt <= '0;
        end
        else if (|slaveSel && waitCnt < curWaits)
        begin
            waitCnt <= waitCnt + 1'b1;
        end
    end

    // Slave models
    always_comb
    begin
        for (int k = 0; k < numExtSlots; k++)
        begin
            slaveResp[k] = '0;
            if (slaveSel[k] && slaveReq.enable)
            begin
                slaveResp[k].ready  = (waitCnt >= curWaits);
                slaveResp[k].slverr = (waitCnt >= curWaits) && curErr;
                slaveResp[k].rdata  = {4{4'h0, 4'(k)}} ^ slaveReq.addr;
            end
        end
    end

    function automatic logic [31:0] nextRandom(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic fillTable();
        // slot, offset, write, random, wdata, waits, err
        rows[0]  = '{4'hF, 12'h000, 1'b0, 1'b0, 32'h0000_0000, 4'd0, 1'b0};
        rows[1]  = '{4'h0, 12'h010, 1'b0, 1'b0, 32'h0000_0000, 4'd0, 1'b0};
        rows[2]  = '{4'h1, 12'h124, 1'b1, 1'b0, 32'h1234_5678, 4'd1, 1'b0};
        rows[3]  = '{4'h2, 12'h0FC, 1'b0, 1'b0, 32'h0000_0000, 4'd3, 1'b0};
        rows[4]  = '{4'h3, 12'h200, 1'b0, 1'b0, 32'h0000_0000, 4'd2, 1'b1};
        rows[5]  = '{4'hF, 12'h000, 1'b1, 1'b0, 32'hABCD_0000, 4'd0, 1'b0};
        rows[6]  = '{4'hF, 12'h000, 1'b0, 1'b0, 32'h0000_0000, 4'd0, 1'b0};
        rows[7]  = '{4'h4, 12'h040, 1'b0, 1'b0, 32'h0000_0000, 4'd0, 1'b0};
        rows[8]  = '{4'h7, 12'h300, 1'b1, 1'b1, 32'h0000_0000, 4'd2, 1'b0};
        rows[9]  = '{4'hE, 12'hFFC, 1'b0, 1'b0, 32'h0000_0000, 4'd1, 1'b1};
        rows[10] = '{4'hF, 12'h004, 1'b1, 1'b1, 32'h0000_0000, 4'd0, 1'b0};
        rows[11] = '{4'hF, 12'h008, 1'b0, 1'b0, 32'h0000_0000, 4'd0, 1'b0};
        rows[12] = '{4'h9, 12'hABC, 1'b0, 1'b0, 32'h0000_0000, 4'd4, 1'b0};
        rows[13] = '{4'hD, 12'h010, 1'b1, 1'b0, 32'hDEAD_BEEF, 4'd0, 1'b1};
        rows[14] = '{4'h5, 12'h7F0, 1'b0, 1'b0, 32'h0000_0000, 4'd1, 1'b0};
        rows[15] = '{4'hF, 12'h000, 1'b1, 1'b0, 32'h0000_0000, 4'd0, 1'b0};
        rows[16] = '{4'hC, 12'h020, 1'b0, 1'b0, 32'h0000_0000, 4'd2, 1'b0};
    endtask

    // Setup phase, access phase until ready, then one idle cycle
    task automatic runRow(input int idx);
        rowT         r;
        logic [31:0] data;
        int          cycles;
        logic        done;

        r = rows[idx];
        data = r.wdata;
        if (r.rnd)
        begin
            rngState = nextRandom(rngState);
            data = rngState;
        end

        @(posedge pclk);
        req.addr.word <= {r.slot, r.offset};
        req.write     <= r.write;
        req.sel       <= 1'b1;
        req.enable    <= 1'b0;
        req.wdata     <= data;
        curWaits      <= r.waits;
        curErr        <= r.err;

        @(posedge pclk);
        req.enable <= 1'b1;

        cycles = 0;
        done = 1'b0;
        while (!done && cycles < readyTimeout)
        begin
            @(negedge pclk);
            if (resp.ready)
            begin
                done = 1'b1;
            end
            else
            begin
                cycles++;
            end
        end
        if (!done)
        begin
            $display("Timeout: slot %0d gave no ready within %0d cycles", r.slot, readyTimeout);
            timeouts++;
        end

        @(posedge pclk);
        req.sel    <= 1'b0;
        req.enable <= 1'b0;
    endtask

    initial
    begin
        req = '0;
        rstN = 1'b0;
        curWaits = '0;
        curErr = 1'b0;
        rngState = 32'h0f6c695c;
        fillTable();

        repeat (4) @(posedge pclk);
        rstN <= 1'b1;

        for (int i = 0; i < numRows; i++)
        begin
            runRow(i);
        end
        @(posedge pclk);
        @(posedge pclk);

        $display("Checks finished: %0d mismatches, %0d timeouts", mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0)
        begin
            $display("ALL TESTS PASSED");
        end
        else
        begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tests/apbFabricChecker.sv */
`timescale 1ns/1ps
`default_nettype none

module apbFabricChecker
(
    input  wire                                         pclk,
    input  wire                                         rstN,
    input  wire apbFabricPkg::apbReqT                   req,
    input  wire apbFabricPkg::apbRespT                  resp,
    input  wire apbFabricPkg::slaveReqT                 slaveReq,
    input  wire [apbFabricPkg::numExtSlots-1:0]         slaveSel,
    input  wire [3:0]                                   waits,
    input  wire                                         err,
    output int                                          mismatches
);
    import apbFabricPkg::*;

    logic [dataWidth-1:0] modelReg;
    int                   accessCycles = 0;
    int                   errCount = 0;

    assign mismatches = errCount;

    task automatic compareValue
    (
        input string       name,
        input logic [31:0] expected,
        input logic [31:0] actual
    );
        if (expected !== actual)
        begin
            $display("Error at %0t ns: %s expected %h actual %h", $time, name, expected, actual);
            errCount++;
        end
    endtask

    // Indirect register, written on the completing edge of a slot 15 write
    always @(posedge pclk)
    begin
        if (!rstN)
        begin
            modelReg <= '0;
        end
        else if (req.sel && req.enable && req.write && req.addr.fields.slot == regSlot)
        begin
            modelReg <= req.wdata;
        end
    end

    // Mid-cycle, all inputs and the combinational paths have settled
    always @(negedge pclk)
    begin : sampleCycle
        logic [numExtSlots-1:0] expSel;
        logic [dataWidth-1:0]   expAddr;
        logic [slotBits-1:0]    slot;
        logic                   expReady;

        if (rstN)
        begin
            slot = req.addr.fields.slot;
            expSel = '0;
            if (req.sel && slot != regSlot)
            begin
                expSel[slot] = 1'b1;
            end
            expAddr = {modelReg[31:16], req.addr.word};

            compareValue("slaveSel", 32'(expSel), 32'(slaveSel));
            compareValue("slaveReq.addr", expAddr, slaveReq.addr);
            compareValue("slaveReq.write", 32'(req.write), 32'(slaveReq.write));
            compareValue("slaveReq.enable", 32'(req.enable), 32'(slaveReq.enable));
            compareValue("slaveReq.wdata", req.wdata, slaveReq.wdata);

            if (!req.sel)
            begin
                // Nothing selected
                compareValue("resp.ready", 32'h1, 32'(resp.ready));
                compareValue("resp.slverr", 32'h0, 32'(resp.slverr));
                compareValue("resp.rdata", 32'h0, resp.rdata);
            end
            else if (req.enable && slot == regSlot)
            begin
                compareValue("resp.ready", 32'h1, 32'(resp.ready));
                compareValue("resp.slverr", 32'h0, 32'(resp.slverr));
                if (!req.write)
                begin
                    compareValue("resp.rdata", modelReg, resp.rdata);
                end
            end
            else if (req.enable)
            begin
                expReady = (accessCycles >= int'(waits));
                compareValue("resp.ready", 32'(expReady), 32'(resp.ready));
                compareValue("resp.slverr", 32'(expReady && err), 32'(resp.slverr));
                if (expReady && !req.write)
                begin
                    // Slave k answers k in every byte, XOR its address
                    compareValue("resp.rdata", {4{4'h0, slot}} ^ expAddr, resp.rdata);
                end
            end
        end

        if (req.enable)
        begin
            accessCycles++;
        end
        else
        begin
            accessCycles = 0;
        end
    end

endmodule

`default_nettype wire

/* hdl/apbFabric.sv */
`timescale 1ns/1ps
`default_nettype none

module apbFabric
(
    input  wire                                                         pclk,
    input  wire                                                         rstN,
    input  wire apbFabricPkg::apbReqT                                   req,
    output apbFabricPkg::apbRespT                                       resp,
    output apbFabricPkg::slaveReqT                                      slaveReq,
    output logic [apbFabricPkg::numExtSlots-1:0]                        slaveSel,
    input  wire apbFabricPkg::apbRespT [apbFabricPkg::numExtSlots-1:0]  slaveResp
);
    import apbFabricPkg::*;

    logic                   regSel;
    logic [numSlots-1:0]    slotHit;
    apbRespT                regResp;
    logic [dataWidth-1:0]   slaveAddr;

    slotDecoder u_slotDecoder
    (
        .req      (req),
        .slaveSel (slaveSel),
        .regSel   (regSel),
        .slotHit  (slotHit)
    );

    indirectAddrReg u_indirectAddrReg
    (
        .pclk      (pclk),
        .rstN      (rstN),
        .req       (req),
        .regSel    (regSel),
        .regResp   (regResp),
        .slaveAddr (slaveAddr)
    );

    responseMux u_responseMux
    (
        .slotHit   (slotHit),
        .slaveResp (slaveResp),
        .regResp   (regResp),
        .resp      (resp)
    );

    // Control and data go straight to every slave
    assign slaveReq.addr   = slaveAddr;
    assign slaveReq.write  = req.write;
    assign slaveReq.enable = req.enable;
    assign slaveReq.wdata  = req.wdata;

    // Master holds its request while a slave stalls
    property holdDuringWait;
        @(posedge pclk) disable iff (!rstN)
        (req.sel && req.enable && !resp.ready) |=> $stable(req);
    endproperty

    assert property (holdDuringWait)
    else
    begin
        $error("apbFabric: master request changed during a wait state");
    end

endmodule

`default_nettype wire

/* hdl/responseMux.sv */
`timescale 1ns/1ps
`default_nettype none

module responseMux
(
    input  wire [apbFabricPkg::numSlots-1:0]                            slotHit,
    input  wire apbFabricPkg::apbRespT [apbFabricPkg::numExtSlots-1:0]  slaveResp,
    input  wire apbFabricPkg::apbRespT                                  regResp,
    output apbFabricPkg::apbRespT                                       resp
);
    import apbFabricPkg::*;

    apbRespT picked;

    // slotHit is one-hot or zero, so order of the checks does not matter
    always_comb
    begin
        picked = idleResp;
        for (int k = 0; k < numExtSlots; k++)
        begin
            if (slotHit[k])
            begin
                picked = slaveResp[k];
            end
        end
        if (slotHit[regSlot])
        begin
            picked = regResp;
        end
    end

    assign resp = picked;

    // Slaves may only flag an error on the completing cycle
    always_comb
    begin
        assert final (!(|slotHit && resp.slverr && !resp.ready))
        else
        begin
            $error("responseMux: slverr high while ready low (hit %b)", slotHit);
        end
    end

endmodule

`default_nettype wire

/* hdl/indirectAddrReg.sv */
`timescale 1ns/1ps
`default_nettype none

module indirectAddrReg
(
    input  wire                                         pclk,
    input  wire                                         rstN,
    input  wire apbFabricPkg::apbReqT                   req,
    input  wire                                         regSel,
    output apbFabricPkg::apbRespT                       regResp,
    output logic [apbFabricPkg::dataWidth-1:0]          slaveAddr
);
    import apbFabricPkg::*;

    logic [dataWidth-1:0] indirectAddr;
    logic                 wrEn;

    // Access phase of a selected write
    assign wrEn = regSel & req.enable & req.write;

    always_ff @(posedge pclk)
    begin
        if (!rstN)
        begin
            indirectAddr <= '0;
        end
        else if (wrEn)
        begin
            indirectAddr <= req.wdata;
        end
    end

    // Register never stalls and never errors
    assign regResp.rdata  = indirectAddr;
    assign regResp.ready  = 1'b1;
    assign regResp.slverr = 1'b0;

    // Upper half fills in above the 16-bit master address
    assign slaveAddr = {indirectAddr[dataWidth-1:masterAddrWidth], req.addr.word};

    // Register access phase follows its setup phase with the same data
    property regSetupFirst;
        @(posedge pclk) disable iff (!rstN)
        (regSel && req.enable) |-> ($past(regSel && !req.enable) && $stable(req.wdata));
    endproperty

    assert property (regSetupFirst)
    else
    begin
        $error("indirectAddrReg: register access phase without a matching setup phase");
    end

endmodule

`default_nettype wire

/* hdl/slotDecoder.sv */
`timescale 1ns/1ps
`default_nettype none

module slotDecoder
(
    input  wire apbFabricPkg::apbReqT                   req,
    output logic [apbFabricPkg::numExtSlots-1:0]        slaveSel,
    output logic                                        regSel,
    output logic [apbFabricPkg::numSlots-1:0]           slotHit
);
    import apbFabricPkg::*;

    logic [slotBits-1:0] slot;

    assign slot = req.addr.fields.slot;

    // One-hot select gated by the master sel
    always_comb
    begin
        slotHit = '0;
        if (req.sel)
        begin
            slotHit[slot] = 1'b1;
        end
    end

    assign slaveSel = slotHit[numExtSlots-1:0];
    assign regSel   = slotHit[regSlot];

endmodule

`default_nettype wire

/* hdl/apbFabricPkg.sv */
`default_nettype none

package apbFabricPkg;

    localparam int dataWidth       = 32;
    localparam int masterAddrWidth = 16;
    localparam int slotBits        = 4;
    localparam int offsetBits      = masterAddrWidth - slotBits;
    localparam int numSlots        = 2 ** slotBits;
    localparam int numExtSlots     = numSlots - 1;

    // Last slot is the indirect address register
    localparam logic [slotBits-1:0] regSlot = slotBits'(numSlots - 1);

    // Top nibble picks the slot, the rest goes to the slave
    typedef struct packed {
        logic [slotBits-1:0]   slot;
        logic [offsetBits-1:0] offset;
    } slotAddrT;

    typedef union packed {
        logic [masterAddrWidth-1:0] word;
        slotAddrT                   fields;
    } masterAddrT;

    typedef struct packed {
        masterAddrT             addr;
        logic                   write;
        logic                   enable;
        logic                   sel;
        logic [dataWidth-1:0]   wdata;
    } apbReqT;

    // Shared by every slave, the select lines travel separately
    typedef struct packed {
        logic [dataWidth-1:0]   addr;
        logic                   write;
        logic                   enable;
        logic [dataWidth-1:0]   wdata;
    } slaveReqT;

    typedef struct packed {
        logic [dataWidth-1:0]   rdata;
        logic                   ready;
        logic                   slverr;
    } apbRespT;

    // Answer when nothing is selected
    localparam apbRespT idleResp = '{
        rdata:  '0,
        ready:  1'b1,
        slverr: 1'b0
    };

endpackage

`default_nettype wire
